// ==== dv/tb_packet_reorder_filter.sv ====
/*
 * Packet reorder filter testbench
 * Queue model of admitted packets with shuffled verdicts, checked by assertions
 */
`timescale 1ns/1ps

module tb_packet_reorder_filter;

    localparam int DATA_WIDTH    = 64;
    localparam int TAG_WIDTH     = 4;
    localparam int BEAT_DEPTH    = 64;
    localparam int MAX_PKT_BEATS = 8;
    localparam int NUM_TAGS      = 1 << TAG_WIDTH;
    // 6 batches of at most 48 beats plus two 24 packet overflow runs, ~300 cycles each worst case
    localparam int CYCLE_LIMIT   = 4000;

    logic                              clk;
    logic                              rst_n;
    logic                              sn_valid;
    logic [DATA_WIDTH-1:0]             sn_data;
    logic                              sn_last;
    logic                              pkt_start;
    logic [TAG_WIDTH-1:0]              pkt_tag;
    logic                              verdict_valid;
    logic [TAG_WIDTH-1:0]              verdict_tag;
    logic                              verdict_accept;
    logic                              cb_valid;
    logic [DATA_WIDTH-1:0]             cb_data;
    logic                              cb_last;
    logic [TAG_WIDTH-1:0]              cb_tag;
    logic                              cb_ready;
    logic [pf_pkg::DROP_CNT_WIDTH-1:0] num_packets_dropped;

    // Store model, exact while nothing is popped
    int                                m_fill;          // Beats held
    int                                m_out;           // Tagged packets in flight
    logic [TAG_WIDTH-1:0]              m_next_tag;
    logic                              exp_start;       // Travels with each snoop beat
    logic [TAG_WIDTH-1:0]              exp_tag_start;
    logic [pf_pkg::DROP_CNT_WIDTH-1:0] drops_expected;
    logic                              drop_check;      // Drop count is settled

    // Admitted packets of the current batch
    logic [TAG_WIDTH-1:0]              b_tag [$];
    int                                b_first [$];     // Index of first beat in b_data
    int                                b_len [$];
    logic [DATA_WIDTH-1:0]             b_data [$];
    logic                              b_last [$];

    // Expected output stream, consumed by index
    logic [DATA_WIDTH-1:0]             exp_data_q [$];
    logic                              exp_last_q [$];
    logic [TAG_WIDTH-1:0]              exp_tag_q [$];
    int                                rd_idx;
    bit                                exp_avail;
    logic [DATA_WIDTH-1:0]             exp_data;
    logic                              exp_last;
    logic [TAG_WIDTH-1:0]              exp_tag;

    int ready_pct;      // Chance of cb_ready per cycle
    int errors;
    int err_base;
    int test_count;
    int cycle_cnt;

    packet_reorder_filter #(
        .DATA_WIDTH   (DATA_WIDTH),
        .TAG_WIDTH    (TAG_WIDTH),
        .BEAT_DEPTH   (BEAT_DEPTH),
        .MAX_PKT_BEATS(MAX_PKT_BEATS)
    ) packet_reorder_filter_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .sn_valid           (sn_valid),
        .sn_data            (sn_data),
        .sn_last            (sn_last),
        .pkt_start          (pkt_start),
        .pkt_tag            (pkt_tag),
        .verdict_valid      (verdict_valid),
        .verdict_tag        (verdict_tag),
        .verdict_accept     (verdict_accept),
        .cb_valid           (cb_valid),
        .cb_data            (cb_data),
        .cb_last            (cb_last),
        .cb_tag             (cb_tag),
        .cb_ready           (cb_ready),
        .num_packets_dropped(num_packets_dropped)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    // Random gaps on the output side
    initial begin
        cb_ready = 1'b0;
        forever begin
            @(posedge clk);
            cb_ready <= (($urandom % 100) < ready_pct);
        end
    end

    // Head of the expected stream, advanced on each transfer
    always @(posedge clk) begin
        if (cb_valid && cb_ready && rd_idx < exp_data_q.size())
            rd_idx = rd_idx + 1;
        exp_avail <= (rd_idx < exp_data_q.size());
        if (rd_idx < exp_data_q.size()) begin
            exp_data <= exp_data_q[rd_idx];
            exp_last <= exp_last_q[rd_idx];
            exp_tag  <= exp_tag_q[rd_idx];
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, output stream never drained", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Quiet outputs while reset is held
    assert property (@(posedge clk) !rst_n |-> (!cb_valid && !pkt_start && num_packets_dropped == '0))
        else begin
            errors++;
            $display("CHECK FAILED reset: cb_valid=%h pkt_start=%h num_packets_dropped=%h",
                     $sampled(cb_valid), $sampled(pkt_start), $sampled(num_packets_dropped));
        end

    assert property (@(posedge clk) disable iff (!rst_n) pkt_start == exp_start)
        else begin
            errors++;
            $display("CHECK FAILED pkt_start: got %h, expected %h",
                     $sampled(pkt_start), $sampled(exp_start));
        end

    assert property (@(posedge clk) disable iff (!rst_n) pkt_start |-> pkt_tag == exp_tag_start)
        else begin
            errors++;
            $display("CHECK FAILED pkt_tag: got %h, expected %h",
                     $sampled(pkt_tag), $sampled(exp_tag_start));
        end

    assert property (@(posedge clk) disable iff (!rst_n) (cb_valid && cb_ready) |-> exp_avail)
        else begin
            errors++;
            $display("Output beat transferred while no accepted packet was waiting");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     (cb_valid && cb_ready && exp_avail) |-> cb_data == exp_data)
        else begin
            errors++;
            $display("CHECK FAILED cb_data: got %h, expected %h",
                     $sampled(cb_data), $sampled(exp_data));
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     (cb_valid && cb_ready && exp_avail) |-> cb_last == exp_last)
        else begin
            errors++;
            $display("CHECK FAILED cb_last: got %h, expected %h",
                     $sampled(cb_last), $sampled(exp_last));
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     (cb_valid && cb_ready && exp_avail) |-> cb_tag == exp_tag)
        else begin
            errors++;
            $display("CHECK FAILED cb_tag: got %h, expected %h",
                     $sampled(cb_tag), $sampled(exp_tag));
        end

    // Stalled beat must hold until taken
    assert property (@(posedge clk) disable iff (!rst_n) (cb_valid && !cb_ready) |=>
                     (cb_valid && $stable(cb_data) && $stable(cb_last) && $stable(cb_tag)))
        else begin
            errors++;
            $display("Output beat changed or vanished while cb_ready was low");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     drop_check |-> num_packets_dropped == drops_expected)
        else begin
            errors++;
            $display("CHECK FAILED num_packets_dropped: got %h, expected %h",
                     $sampled(num_packets_dropped), $sampled(drops_expected));
        end

    // Store is known empty here
    task automatic start_batch();
        b_tag.delete();
        b_first.delete();
        b_len.delete();
        b_data.delete();
        b_last.delete();
        m_fill = 0;
        m_out  = 0;
    endtask

    task automatic send_packet(input int len);
        logic                  admit;
        logic [DATA_WIDTH-1:0] beat;
        int                    i;
        admit = (m_out < NUM_TAGS) && ((BEAT_DEPTH - m_fill) >= MAX_PKT_BEATS);
        if (admit) begin
            b_tag.push_back(m_next_tag);
            b_first.push_back(b_data.size());
            b_len.push_back(len);
        end
        for (i = 0; i < len; i++) begin
            @(posedge clk);
            beat = {$urandom, $urandom};
            sn_valid      <= 1'b1;
            sn_data       <= beat;
            sn_last       <= (i == len - 1);
            exp_start     <= admit && (i == 0);
            exp_tag_start <= m_next_tag;
            if (i == 0 && !admit)
                drops_expected <= drops_expected + 1'b1;
            if (admit) begin
                b_data.push_back(beat);
                b_last.push_back(i == len - 1);
            end
        end
        if (admit) begin
            m_next_tag = m_next_tag + 1'b1;     // Modulo 16
            m_fill     = m_fill + len;
            m_out      = m_out + 1;
        end
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        sn_valid  <= 1'b0;
        sn_last   <= 1'b0;
        exp_start <= 1'b0;
    endtask

    // Pick verdicts, queue accepted beats in arrival order, strobe verdicts shuffled
    task automatic close_batch(input int accept_pct);
        int   n;
        int   j;
        int   k;
        int   tmp;
        int   order [$];
        logic acc [$];
        n = b_tag.size();
        for (j = 0; j < n; j++) begin
            acc.push_back((($urandom % 100) < accept_pct) || (j == n - 1));   // Last one marks drain
            order.push_back(j);
            if (acc[j]) begin
                for (k = 0; k < b_len[j]; k++) begin
                    exp_data_q.push_back(b_data[b_first[j] + k]);
                    exp_last_q.push_back(b_last[b_first[j] + k]);
                    exp_tag_q.push_back(b_tag[j]);
                end
            end
        end
        for (j = n - 1; j > 0; j--) begin
            k        = int'($urandom % (j + 1));
            tmp      = order[j];
            order[j] = order[k];
            order[k] = tmp;
        end
        for (j = 0; j < n; j++) begin
            @(posedge clk);
            verdict_valid  <= 1'b1;
            verdict_tag    <= b_tag[order[j]];
            verdict_accept <= acc[order[j]];
        end
        @(posedge clk);
        verdict_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (rd_idx < exp_data_q.size())
            @(posedge clk);
    endtask

    task automatic run_batch(input int n_pkts, input int accept_pct);
        start_batch();
        repeat (n_pkts) send_packet(1 + int'($urandom % MAX_PKT_BEATS));
        idle_inputs();
        close_batch(accept_pct);
        wait_drain();
    endtask

    // Output blocked and no verdicts while packets pile up, then drain
    task automatic overflow_batch(input int n_pkts, input int max_len);
        ready_pct = 0;
        drop_check <= 1'b0;
        start_batch();
        repeat (n_pkts) send_packet(1 + int'($urandom % max_len));
        idle_inputs();
        @(posedge clk);
        drop_check <= 1'b1;
        @(posedge clk);
        ready_pct = 70;
        close_batch(60);
        wait_drain();
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("Test %0d %s: %0d failed checks", test_count, name, errors - err_base);
        err_base = errors;
    endtask

    initial begin
        void'($urandom(5076));
        rst_n          = 1'b1;
        sn_valid       = 1'b0;
        sn_data        = '0;
        sn_last        = 1'b0;
        verdict_valid  = 1'b0;
        verdict_tag    = '0;
        verdict_accept = 1'b0;
        exp_start      = 1'b0;
        exp_tag_start  = '0;
        drops_expected = '0;
        drop_check     = 1'b1;
        m_next_tag     = '0;
        ready_pct      = 70;
        #1 rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        finish_test("reset values");

        repeat (2) run_batch(6, 100);     // Shuffled verdicts, all accepted
        finish_test("arrival order release");
        repeat (3) run_batch(6, 50);
        finish_test("accept and reject mix");
        ready_pct = 20;                   // Long stalls on the output
        run_batch(5, 100);
        finish_test("hold under back-pressure");

        overflow_batch(24, 2);              // Short packets, tags run out first
        overflow_batch(24, MAX_PKT_BEATS);  // Beat space runs out first
        finish_test("overflow drops and drain");

        repeat (5) @(posedge clk);
        $display("Tests run: %0d, checks failed: %0d", test_count, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

TOP=tb_packet_reorder_filter
LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" -Mdir obj_dir -o "V$TOP" -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== source/packet_reorder_filter.sv ====
/*
 * Packet reorder filter top level
 * Buffers snooped packets and releases accepted ones in arrival order
 */
`timescale 1ns/1ps

module packet_reorder_filter #(
    parameter int DATA_WIDTH    = 64,
    parameter int TAG_WIDTH     = 4,    // 16 tags in flight
    parameter int BEAT_DEPTH    = 64,
    parameter int MAX_PKT_BEATS = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // Snoop stream
    input  logic                              sn_valid,
    input  logic [DATA_WIDTH-1:0]             sn_data,
    input  logic                              sn_last,

    // Tag announcement toward the filter side
    output logic                              pkt_start,
    output logic [TAG_WIDTH-1:0]              pkt_tag,

    // Verdicts in any tag order
    input  logic                              verdict_valid,
    input  logic [TAG_WIDTH-1:0]              verdict_tag,
    input  logic                              verdict_accept,

    // Reordered output stream
    output logic                              cb_valid,
    output logic [DATA_WIDTH-1:0]             cb_data,
    output logic                              cb_last,
    output logic [TAG_WIDTH-1:0]              cb_tag,
    input  logic                              cb_ready,

    output logic [pf_pkg::DROP_CNT_WIDTH-1:0] num_packets_dropped
);

    logic                  head_valid;
    logic [DATA_WIDTH-1:0] head_data;
    logic                  head_last;
    logic                  head_pop;
    logic [TAG_WIDTH-1:0]  head_tag;
    pf_pkg::pkt_status_e   head_status;
    logic                  retire;
    logic [TAG_WIDTH-1:0]  retire_tag;

    packet_store #(
        .DATA_WIDTH   (DATA_WIDTH),
        .TAG_WIDTH    (TAG_WIDTH),
        .BEAT_DEPTH   (BEAT_DEPTH),
        .MAX_PKT_BEATS(MAX_PKT_BEATS)
    ) packet_store_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .sn_valid           (sn_valid),
        .sn_data            (sn_data),
        .sn_last            (sn_last),
        .head_pop           (head_pop),
        .retire             (retire),
        .pkt_start          (pkt_start),
        .pkt_tag            (pkt_tag),
        .head_valid         (head_valid),
        .head_data          (head_data),
        .head_last          (head_last),
        .num_packets_dropped(num_packets_dropped)
    );

    status_table #(
        .TAG_WIDTH(TAG_WIDTH)
    ) status_table_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .verdict_valid (verdict_valid),
        .verdict_tag   (verdict_tag),
        .verdict_accept(verdict_accept),
        .head_tag      (head_tag),
        .retire        (retire),
        .retire_tag    (retire_tag),
        .head_status   (head_status)
    );

    // Combines buffer head and tag status into the output stream
    release_ctrl #(
        .DATA_WIDTH(DATA_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) release_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_data  (head_data),
        .head_last  (head_last),
        .head_pop   (head_pop),
        .head_tag   (head_tag),
        .head_status(head_status),
        .retire     (retire),
        .retire_tag (retire_tag),
        .cb_valid   (cb_valid),
        .cb_data    (cb_data),
        .cb_last    (cb_last),
        .cb_tag     (cb_tag),
        .cb_ready   (cb_ready)
    );

endmodule

// ==== source/packet_store.sv ====
/*
 * Packet store
 * Cuts the snoop stream into packets, tags or drops each one, buffers beats in a ring
 */
`timescale 1ns/1ps

module packet_store #(
    parameter int DATA_WIDTH    = 64,
    parameter int TAG_WIDTH     = 4,
    parameter int BEAT_DEPTH    = 64,
    parameter int MAX_PKT_BEATS = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // Snoop stream, no back-pressure
    input  logic                              sn_valid,
    input  logic [DATA_WIDTH-1:0]             sn_data,
    input  logic                              sn_last,

    // From release walker
    input  logic                              head_pop,
    input  logic                              retire,

    // Tag announcement
    output logic                              pkt_start,
    output logic [TAG_WIDTH-1:0]              pkt_tag,

    // Oldest stored beat
    output logic                              head_valid,
    output logic [DATA_WIDTH-1:0]             head_data,
    output logic                              head_last,

    output logic [pf_pkg::DROP_CNT_WIDTH-1:0] num_packets_dropped
);

    localparam int PTR_WIDTH  = $clog2(BEAT_DEPTH);
    localparam int CNT_WIDTH  = $clog2(BEAT_DEPTH + 1);
    localparam int NUM_TAGS   = 1 << TAG_WIDTH;
    localparam int OUT_WIDTH  = TAG_WIDTH + 1;    // Must hold NUM_TAGS itself
    localparam int FILL_LIMIT = BEAT_DEPTH - MAX_PKT_BEATS;

    // Beat memory, last flag on top of data
    logic [DATA_WIDTH:0]  mem [BEAT_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] fill;           // Beats currently stored
    logic [OUT_WIDTH-1:0] outstanding;    // Tagged packets not yet retired
    logic [TAG_WIDTH-1:0] next_tag;

    logic pkt_open;     // A packet is in progress on the snoop stream
    logic pkt_admit;    // The open packet was admitted

    logic first_beat;
    logic admit_ok;
    logic wr_en;
    logic do_pop;
    logic drop_evt;

    // Admission is decided once, at the first beat
    assign first_beat = sn_valid && !pkt_open;
    assign admit_ok   = (outstanding < OUT_WIDTH'(NUM_TAGS)) &&
                        (fill <= CNT_WIDTH'(FILL_LIMIT));
    assign pkt_start  = first_beat && admit_ok;
    assign pkt_tag    = next_tag;
    assign drop_evt   = first_beat && !admit_ok;

    // Later beats follow the verdict of the first one
    assign wr_en  = sn_valid && (first_beat ? admit_ok : pkt_admit);
    assign do_pop = head_pop && head_valid;

    // Packet framing on the snoop side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_open  <= 1'b0;
            pkt_admit <= 1'b0;
        end else if (sn_valid) begin
            pkt_open <= !sn_last;               // Single-beat packets never open
            if (first_beat)
                pkt_admit <= admit_ok;
        end
    end

    // Tag issue and in-flight count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_tag    <= '0;
            outstanding <= '0;
        end else begin
            if (pkt_start)
                next_tag <= next_tag + 1'b1;    // Wraps modulo NUM_TAGS
            case ({pkt_start, retire})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Ring pointers and fill level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_WIDTH'(BEAT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_WIDTH'(BEAT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= {sn_last, sn_data};
    end

    // Drop count shows up one cycle after the rejected first beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            num_packets_dropped <= '0;
        else if (drop_evt)
            num_packets_dropped <= num_packets_dropped + 1'b1;
    end

    // Combinational head read
    assign head_valid = (fill != '0);
    assign head_data  = mem[rd_ptr][DATA_WIDTH-1:0];
    assign head_last  = mem[rd_ptr][DATA_WIDTH];

endmodule

// ==== source/pf_pkg.sv ====
/*
 * Packet reorder filter shared types
 * Tag status and release walker encodings, plus the drop counter width
 */
package pf_pkg;

    // Verdict status held per reorder tag
    typedef enum logic [1:0] {
        STATUS_PENDING = 2'd0,  // Stored, no verdict yet
        STATUS_ACCEPT  = 2'd1,  // Forward to output stream
        STATUS_REJECT  = 2'd2   // Discard from buffer
    } pkt_status_e;

    // Release walker states
    typedef enum logic [1:0] {
        REL_IDLE         = 2'd0,  // Buffer empty, nothing to walk
        REL_WAIT_VERDICT = 2'd1,  // Head packet stored, status still pending
        REL_SEND         = 2'd2,  // Forwarding head packet
        REL_DISCARD      = 2'd3   // Dropping head packet
    } release_state_e;

    // Dropped packet counter width
    localparam int DROP_CNT_WIDTH = 16;

endpackage

// ==== source/release_ctrl.sv ====
/*
 * Release controller
 * Walks the buffer head in tag order, forwarding accepted and dropping rejected packets
 */
`timescale 1ns/1ps

module release_ctrl #(
    parameter int DATA_WIDTH = 64,
    parameter int TAG_WIDTH  = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Buffer head
    input  logic                  head_valid,
    input  logic [DATA_WIDTH-1:0] head_data,
    input  logic                  head_last,
    output logic                  head_pop,

    // Status lookup and retire
    output logic [TAG_WIDTH-1:0]  head_tag,
    input  pf_pkg::pkt_status_e   head_status,
    output logic                  retire,
    output logic [TAG_WIDTH-1:0]  retire_tag,

    // Output stream
    output logic                  cb_valid,
    output logic [DATA_WIDTH-1:0] cb_data,
    output logic                  cb_last,
    output logic [TAG_WIDTH-1:0]  cb_tag,
    input  logic                  cb_ready
);

    pf_pkg::release_state_e state;
    pf_pkg::release_state_e state_next;

    logic [TAG_WIDTH-1:0] exp_tag;    // Tag of the packet at the head
    logic                 out_free;   // Output register can take a beat
    logic                 load;

    assign out_free = !cb_valid || cb_ready;

    // Next state and pop decision
    always_comb begin
        state_next = state;
        head_pop   = 1'b0;
        case (state)
            pf_pkg::REL_IDLE: begin
                if (head_valid)
                    state_next = pf_pkg::REL_WAIT_VERDICT;
            end
            pf_pkg::REL_WAIT_VERDICT: begin
                if (head_status == pf_pkg::STATUS_ACCEPT)
                    state_next = pf_pkg::REL_SEND;
                else if (head_status == pf_pkg::STATUS_REJECT)
                    state_next = pf_pkg::REL_DISCARD;
            end
            pf_pkg::REL_SEND: begin
                head_pop = head_valid && out_free;     // One beat per cycle under ready
                if (head_pop && head_last)
                    state_next = pf_pkg::REL_IDLE;
            end
            pf_pkg::REL_DISCARD: begin
                head_pop = head_valid;                 // Drain at full rate
                if (head_pop && head_last)
                    state_next = pf_pkg::REL_IDLE;
            end
            default: state_next = pf_pkg::REL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= pf_pkg::REL_IDLE;
        else
            state <= state_next;
    end

    // Packet is done once its last beat leaves the buffer
    assign retire     = head_pop && head_last;
    assign retire_tag = exp_tag;
    assign head_tag   = exp_tag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            exp_tag <= '0;
        else if (retire)
            exp_tag <= exp_tag + 1'b1;   // Follows the store's tag order
    end

    // Output register, beats only load while forwarding
    assign load = head_pop && (state == pf_pkg::REL_SEND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cb_valid <= 1'b0;
        else if (load)
            cb_valid <= 1'b1;
        else if (cb_ready)
            cb_valid <= 1'b0;            // Transfer done, nothing new
    end

    // Payload holds while cb_valid waits for ready
    always_ff @(posedge clk) begin
        if (load) begin
            cb_data <= head_data;
            cb_last <= head_last;
            cb_tag  <= exp_tag;
        end
    end

endmodule

// ==== source/status_table.sv ====
/*
 * Status table
 * One verdict entry per reorder tag, set by verdict strobes and cleared at retire
 */
`timescale 1ns/1ps

module status_table #(
    parameter int TAG_WIDTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,

    // Verdict strobe from the filter side
    input  logic                verdict_valid,
    input  logic [TAG_WIDTH-1:0] verdict_tag,
    input  logic                verdict_accept,

    // Lookup for the packet at the buffer head
    input  logic [TAG_WIDTH-1:0] head_tag,

    // Retire of a fully released packet
    input  logic                retire,
    input  logic [TAG_WIDTH-1:0] retire_tag,

    output pf_pkg::pkt_status_e head_status
);

    localparam int NUM_TAGS = 1 << TAG_WIDTH;

    pf_pkg::pkt_status_e status_q [NUM_TAGS];

    pf_pkg::pkt_status_e verdict_status;

    assign verdict_status = verdict_accept ? pf_pkg::STATUS_ACCEPT : pf_pkg::STATUS_REJECT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TAGS; i++)
                status_q[i] <= pf_pkg::STATUS_PENDING;
        end else begin
            // Retire first so a same-cycle verdict on that entry wins
            if (retire)
                status_q[retire_tag] <= pf_pkg::STATUS_PENDING;
            if (verdict_valid)
                status_q[verdict_tag] <= verdict_status;
        end
    end

    // Visible one cycle after the strobe
    assign head_status = status_q[head_tag];

endmodule

// ==== verilog.f ====
source/pf_pkg.sv
source/packet_store.sv
source/status_table.sv
source/release_ctrl.sv
source/packet_reorder_filter.sv
dv/tb_packet_reorder_filter.sv
